/* source/um_consts.svh */
// user module constants for flit layout, buffering, rules and register map
`ifndef UM_CONSTS_SVH
`define UM_CONSTS_SVH

// flit layout
`define UM_FLIT_W 139
`define UM_DATA_W 128

// packet buffer, input enabled only while fill is below threshold
`define UM_FIFO_DEPTH 256
`define UM_FIFO_AW 8
`define UM_RX_THRESH 161

// forwarding rules toward the output controller
`define UM_RULE_W 30
`define UM_RULE_FIFO_MAX 30
`define UM_TAG_HEAD 3'b101
`define UM_TAG_TAIL 3'b110

// local bus decode
`define UM_LB_SEL 4'b0001
`define UM_BLK_ID 2'b00
`define UM_BLK_RAM 2'b01
`define UM_REG_COUNT 8

// read-only ID words, ID0 is ascii "UM"
`define UM_ID0_VAL 32'h0000_554d
`define UM_ID1_VAL 32'h0000_0004
`define UM_ID2_VAL 32'h0000_0001
`define UM_ID3_VAL 32'h0001_0000

`endif

/* source/um_pkg.sv */
// user module types for flits, rules, local bus words and state machines
`default_nettype none

`include "um_consts.svh"

package um_pkg;

	// flit fields
	typedef logic [2:0] flit_tag_t;
	typedef logic [3:0] byte_info_t;
	typedef logic [3:0] port_t;
	typedef logic [`UM_DATA_W-1:0] payload_t;

	// tag sits in the top bits, payload at the bottom
	typedef struct packed {
		flit_tag_t tag;
		byte_info_t byte_info;
		port_t port;
		payload_t payload;
	} cdp_flit_t;

	typedef logic [`UM_RULE_W-1:0] rule_t;
	typedef logic [`UM_FIFO_AW:0] fifo_level_t;	// one extra bit for a full FIFO
	typedef logic [4:0] rule_level_t;

	typedef logic [31:0] lb_word_t;
	typedef logic [27:0] lb_addr_t;

	typedef enum logic {RX_IDLE, RX_ARMED} rx_state_t;
	typedef enum logic {FWD_IDLE, FWD_PACKET} fwd_state_t;

	typedef enum logic [2:0] {
		LB_IDLE,
		LB_ADDRESS,
		LB_WRITE,
		LB_READ,
		LB_ACK
	} lb_state_t;

endpackage

`default_nettype wire

/* source/pkt_rx_buffer.sv */
// packet receive buffer, show-ahead flit FIFO with the input transmit enable
`timescale 1ns/1ps
`default_nettype none

`include "um_consts.svh"

module pkt_rx_buffer
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire um_pkg::cdp_flit_t in_flit,
	output logic tx_enable,
	input wire rdreq,
	output um_pkg::cdp_flit_t q,
	output logic empty
);
	import um_pkg::*;

	logic [`UM_FLIT_W-1:0] mem [`UM_FIFO_DEPTH];
	logic [`UM_FIFO_AW-1:0] wr_ptr;
	logic [`UM_FIFO_AW-1:0] rd_ptr;
	fifo_level_t level;
	logic full;
	logic wr_en;
	logic rd_en;
	rx_state_t state;

	assign full = (level == fifo_level_t'(`UM_FIFO_DEPTH));
	assign empty = (level == '0);
	assign wr_en = in_valid && !full;	// drop on overflow
	assign rd_en = rdreq && !empty;

	// head of queue visible without a read request
	assign q = cdp_flit_t'(mem[rd_ptr]);

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= in_flit;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// arm only with room for a full packet and the input side idle
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			state <= RX_IDLE;
		else
		begin
			case (state)
				RX_IDLE:
				begin
					if (level < fifo_level_t'(`UM_RX_THRESH) && !in_valid)
						state <= RX_ARMED;
				end
				RX_ARMED:
				begin
					if (in_valid)	// packet started, withdraw enable
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	assign tx_enable = (state == RX_ARMED);

endmodule

`default_nettype wire

/* source/pkt_forward.sv */
// packet forwarder, drains buffered packets one at a time to the output controller
`timescale 1ns/1ps
`default_nettype none

`include "um_consts.svh"

module pkt_forward
(
	input wire clk,
	input wire reset,
	input wire out_tx_enable,
	input wire um_pkg::cdp_flit_t fifo_q,
	input wire fifo_empty,
	output logic fifo_rdreq,
	output logic out_valid,
	output um_pkg::cdp_flit_t out_flit
);
	import um_pkg::*;

	fwd_state_t state;
	logic tail_pop;

	// output enable only matters at packet start
	always_comb
	begin
		case (state)
			FWD_IDLE: fifo_rdreq = out_tx_enable && !fifo_empty;
			FWD_PACKET: fifo_rdreq = !fifo_empty;
			default: fifo_rdreq = 1'b0;
		endcase
	end

	assign tail_pop = fifo_rdreq && (fifo_q.tag == `UM_TAG_TAIL);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= FWD_IDLE;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= fifo_rdreq;	// gaps when the FIFO runs dry
			case (state)
				FWD_IDLE:
				begin
					if (fifo_rdreq && !tail_pop)
						state <= FWD_PACKET;
				end
				FWD_PACKET:
				begin
					if (tail_pop)
						state <= FWD_IDLE;
				end
				default: state <= FWD_IDLE;
			endcase
		end
	end

	// flits pass unmodified
	always_ff @(posedge clk)
	begin
		if (fifo_rdreq)
			out_flit <= fifo_q;
	end

endmodule

`default_nettype wire

/* source/rule_gen.sv */
// rule generator, one port-mask rule per packet tail excluding the ingress port
`timescale 1ns/1ps
`default_nettype none

`include "um_consts.svh"

module rule_gen
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire um_pkg::cdp_flit_t in_flit,
	input wire um_pkg::rule_level_t rule_usedw,
	output um_pkg::rule_t rule,
	output logic rule_wrreq
);
	import um_pkg::*;

	port_t in_port;
	logic head_seen;
	logic fire;
	logic [3:0] mask;

	assign head_seen = in_valid && (in_flit.tag == `UM_TAG_HEAD);

	// tail seen, ingress port is a real port, rule FIFO has room
	assign fire = in_valid && (in_flit.tag == `UM_TAG_TAIL)
		&& (in_port[3:2] == 2'b00)
		&& (rule_usedw < rule_level_t'(`UM_RULE_FIFO_MAX));

	assign mask = 4'b1111 & ~(4'b0001 << in_port[1:0]);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			in_port <= '0;
			rule_wrreq <= 1'b0;
		end
		else
		begin
			if (head_seen)
				in_port <= in_flit.port;
			rule_wrreq <= fire;	// single cycle per tail
		end
	end

	always_ff @(posedge clk)
	begin
		if (fire)
			rule <= rule_t'(mask);
	end

endmodule

`default_nettype wire

/* source/localbus_regs.sv */
// local bus slave with the ID and RAM register blocks
`timescale 1ns/1ps
`default_nettype none

`include "um_consts.svh"

module localbus_regs
(
	input wire clk,
	input wire reset,
	input wire ale,
	input wire cs_n,
	input wire rd_wr,
	input wire um_pkg::lb_word_t data_in,
	output logic ack_n,
	output um_pkg::lb_word_t data_out
);
	import um_pkg::*;

	lb_state_t state;
	lb_addr_t addr;
	lb_word_t wr_data;
	lb_word_t rd_word;
	lb_word_t id_regs [`UM_REG_COUNT];
	lb_word_t ram_regs [`UM_REG_COUNT];
	logic [1:0] blk;
	logic [2:0] idx;
	logic idx_ok;

	assign blk = addr[27:26];
	assign idx = addr[2:0];
	assign idx_ok = (addr[7:3] == 5'd0);	// only the low eight indices exist

	// bus handshake
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= LB_IDLE;
			addr <= '0;
			ack_n <= 1'b1;
		end
		else
		begin
			case (state)
				LB_IDLE:
				begin
					if (ale && data_in[31:28] == `UM_LB_SEL)
					begin
						addr <= data_in[27:0];
						state <= LB_ADDRESS;
					end
				end
				LB_ADDRESS:
				begin
					if (!cs_n)
						state <= rd_wr ? LB_READ : LB_WRITE;
				end
				LB_WRITE, LB_READ:
				begin
					ack_n <= 1'b0;
					state <= LB_ACK;
				end
				LB_ACK:
				begin
					if (cs_n)	// host released, finish the cycle
					begin
						ack_n <= 1'b1;
						state <= LB_IDLE;
					end
				end
				default:
				begin
					ack_n <= 1'b1;
					state <= LB_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == LB_ADDRESS && !cs_n && !rd_wr)
			wr_data <= data_in;
	end

	// ID0 to ID3 keep their reset value
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `UM_REG_COUNT; i++)
			begin
				id_regs[i] <= '0;
				ram_regs[i] <= '0;
			end
			id_regs[0] <= `UM_ID0_VAL;
			id_regs[1] <= `UM_ID1_VAL;
			id_regs[2] <= `UM_ID2_VAL;
			id_regs[3] <= `UM_ID3_VAL;
		end
		else if (state == LB_WRITE && idx_ok)
		begin
			if (blk == `UM_BLK_ID && idx[2])
				id_regs[idx] <= wr_data;
			else if (blk == `UM_BLK_RAM)
				ram_regs[idx] <= wr_data;
		end
	end

	always_comb
	begin
		rd_word = '0;	// unmapped space reads zero
		if (idx_ok && blk == `UM_BLK_ID)
			rd_word = id_regs[idx];
		else if (idx_ok && blk == `UM_BLK_RAM)
			rd_word = ram_regs[idx];
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			data_out <= '0;
		else if (state == LB_READ)
			data_out <= rd_word;
	end

endmodule

`default_nettype wire

/* source/um_top.sv */
// user module top, pass-through datapath with forwarding rules and local bus registers
`timescale 1ns/1ps
`default_nettype none

module um_top
(
	input wire clk,
	input wire reset,
	input wire localbus_ale,
	input wire localbus_cs_n,
	input wire localbus_rd_wr,
	input wire um_pkg::lb_word_t localbus_data,
	output logic localbus_ack_n,
	output um_pkg::lb_word_t localbus_data_out,
	input wire cdp2um_data_valid,
	input wire um_pkg::cdp_flit_t cdp2um_data,
	output logic um2cdp_tx_enable,
	input wire cdp2um_tx_enable,
	output logic um2cdp_data_valid,
	output um_pkg::cdp_flit_t um2cdp_data,
	output um_pkg::rule_t um2cdp_rule,
	output logic um2cdp_rule_wrreq,
	input wire um_pkg::rule_level_t cdp2um_rule_usedw
);
	import um_pkg::*;

	cdp_flit_t fifo_q;
	logic fifo_empty;
	logic fifo_rdreq;

	// input side buffering
	pkt_rx_buffer u_rx_buffer (
		.clk(clk),
		.reset(reset),
		.in_valid(cdp2um_data_valid),
		.in_flit(cdp2um_data),
		.tx_enable(um2cdp_tx_enable),
		.rdreq(fifo_rdreq),
		.q(fifo_q),
		.empty(fifo_empty)
	);

	pkt_forward u_forward (
		.clk(clk),
		.reset(reset),
		.out_tx_enable(cdp2um_tx_enable),
		.fifo_q(fifo_q),
		.fifo_empty(fifo_empty),
		.fifo_rdreq(fifo_rdreq),
		.out_valid(um2cdp_data_valid),
		.out_flit(um2cdp_data)
	);

	// watches the same input flits as the buffer
	rule_gen u_rule_gen (
		.clk(clk),
		.reset(reset),
		.in_valid(cdp2um_data_valid),
		.in_flit(cdp2um_data),
		.rule_usedw(cdp2um_rule_usedw),
		.rule(um2cdp_rule),
		.rule_wrreq(um2cdp_rule_wrreq)
	);

	localbus_regs u_localbus (
		.clk(clk),
		.reset(reset),
		.ale(localbus_ale),
		.cs_n(localbus_cs_n),
		.rd_wr(localbus_rd_wr),
		.data_in(localbus_data),
		.ack_n(localbus_ack_n),
		.data_out(localbus_data_out)
	);

endmodule

`default_nettype wire

/* verif/um_sva.sv */
// handshake assertions for the user module, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module um_sva
(
	input wire clk,
	input wire reset,
	input wire cs_n,
	input wire ack_n,
	input wire rule_wrreq,
	input wire rx_tx_enable,
	input wire rx_data_valid
);
	int assert_failures = 0;

	// slave ends the bus cycle only after the host lets go of cs_n
	ack_after_cs: assert property (@(posedge clk) disable iff (!reset)
		$rose(ack_n) |-> $past(cs_n))
	else
	begin
		assert_failures++;
		$error("localbus ack_n rose while cs_n was still low");
	end

	rule_single: assert property (@(posedge clk) disable iff (!reset)
		rule_wrreq |=> !rule_wrreq)	// one write per tail
	else
	begin
		assert_failures++;
		$error("rule write request held for two cycles");
	end

	// enable toward the input controller arms only on an idle input
	enable_idle: assert property (@(posedge clk) disable iff (!reset)
		$rose(rx_tx_enable) |-> !$past(rx_data_valid))
	else
	begin
		assert_failures++;
		$error("input transmit enable rose while data valid was high");
	end

endmodule

bind um_top um_sva u_sva (
	.clk(clk),
	.reset(reset),
	.cs_n(localbus_cs_n),
	.ack_n(localbus_ack_n),
	.rule_wrreq(um2cdp_rule_wrreq),
	.rx_tx_enable(um2cdp_tx_enable),
	.rx_data_valid(cdp2um_data_valid)
);

`default_nettype wire

/* verif/um_tb.sv */
// testbench for the user module, random packets and register traffic against a model
`timescale 1ns/1ps
`default_nettype none

`include "um_consts.svh"

module um_tb;
	import um_pkg::*;

	localparam int wait_limit = 200;
	localparam int drain_limit = 5000;
	localparam int num_packets = 40;

	logic clk = 1'b0;
	logic reset = 1'b0;
	logic localbus_ale = 1'b0;
	logic localbus_cs_n = 1'b1;
	logic localbus_rd_wr = 1'b0;
	lb_word_t localbus_data = '0;
	logic localbus_ack_n;
	lb_word_t localbus_data_out;
	logic cdp2um_data_valid = 1'b0;
	cdp_flit_t cdp2um_data = '0;
	logic um2cdp_tx_enable;
	logic cdp2um_tx_enable = 1'b0;
	logic um2cdp_data_valid;
	cdp_flit_t um2cdp_data;
	rule_t um2cdp_rule;
	logic um2cdp_rule_wrreq;
	rule_level_t cdp2um_rule_usedw = '0;
	logic out_hold = 1'b0;	// stalls the output controller

	cdp_flit_t exp_flits [$];
	rule_t exp_rules [$];
	lb_word_t shadow_id [`UM_REG_COUNT];
	lb_word_t shadow_ram [`UM_REG_COUNT];

	um_top DUT (.*);

	always #5 clk = ~clk;

	// output controller enable, random while out of reset
	always @(posedge clk)
	begin
		#1;
		cdp2um_tx_enable = reset && !out_hold && ($urandom_range(0, 3) != 0);
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flit(input cdp_flit_t got, input cdp_flit_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_rule(input rule_t got, input rule_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_word(input lb_word_t got, input lb_word_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	// mask of every port except the ingress one
	function automatic rule_t expected_rule(input port_t port);
		case (port)
			4'd0: return rule_t'(30'h0e);
			4'd1: return rule_t'(30'h0d);
			4'd2: return rule_t'(30'h0b);
			default: return rule_t'(30'h07);
		endcase
	endfunction

	function automatic lb_word_t make_addr(input logic [1:0] blk, input int index);
		return {`UM_LB_SEL, blk, 18'd0, 8'(index)};
	endfunction

	function automatic lb_word_t expected_reg(input logic [1:0] blk, input int index);
		if (index < `UM_REG_COUNT && blk == `UM_BLK_ID)
			return shadow_id[index];
		if (index < `UM_REG_COUNT && blk == `UM_BLK_RAM)
			return shadow_ram[index];
		return '0;	// unmapped
	endfunction

	// one four-phase bus cycle, starts and ends just after a rising edge
	task automatic lb_access(input logic is_read, input lb_word_t addr, input lb_word_t wdata,
		output lb_word_t rdata);
		int waited;
		localbus_ale = 1'b1;
		localbus_data = addr;
		@(posedge clk);
		#1;
		localbus_ale = 1'b0;
		localbus_cs_n = 1'b0;
		localbus_rd_wr = is_read;
		localbus_data = wdata;
		waited = 0;
		while (localbus_ack_n !== 1'b0)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit)
				stop_run("timeout: localbus ack_n never went low");
		end
		rdata = localbus_data_out;
		localbus_cs_n = 1'b1;
		localbus_data = '0;
		waited = 0;
		while (localbus_ack_n !== 1'b1)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit)
				stop_run("timeout: localbus ack_n never returned high");
		end
	endtask

	task automatic write_reg(input logic [1:0] blk, input int index, input lb_word_t data);
		lb_word_t unused;
		lb_access(1'b0, make_addr(blk, index), data, unused);
		if (blk == `UM_BLK_ID && index >= 4 && index < `UM_REG_COUNT)
			shadow_id[index] = data;
		else if (blk == `UM_BLK_RAM && index < `UM_REG_COUNT)
			shadow_ram[index] = data;
	endtask

	task automatic read_reg(input logic [1:0] blk, input int index);
		lb_word_t got;
		lb_access(1'b1, make_addr(blk, index), '0, got);
		check_word(got, expected_reg(blk, index), $sformatf("block %0d reg %0d", blk, index));
	endtask

	task automatic send_packet(input port_t port, input int len);
		cdp_flit_t flit;
		int waited;
		waited = 0;
		while (um2cdp_tx_enable !== 1'b1)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit)
				stop_run("timeout: um2cdp_tx_enable never rose before a packet");
		end
		for (int i = 0; i < len; i++)
		begin
			flit.tag = (i == 0) ? `UM_TAG_HEAD : (i == len - 1) ? `UM_TAG_TAIL : 3'b100;
			flit.byte_info = byte_info_t'($urandom);
			flit.port = (i == 0) ? port : port_t'($urandom);	// only the head counts
			flit.payload = {$urandom, $urandom, $urandom, $urandom};
			cdp2um_data_valid = 1'b1;
			cdp2um_data = flit;
			cdp2um_rule_usedw = rule_level_t'($urandom_range(24, 31));
			exp_flits.push_back(flit);
			if (i == len - 1 && port < 4 && cdp2um_rule_usedw < `UM_RULE_FIFO_MAX)
				exp_rules.push_back(expected_rule(port));
			@(posedge clk);
			#1;
			if (i == 0)
				check_bit(um2cdp_tx_enable, 1'b0, "um2cdp_tx_enable after head");
		end
		cdp2um_data_valid = 1'b0;
	endtask

	// output side stalled, buffer filled past the threshold, input enable must stay off
	task automatic fill_to_threshold();
		fifo_level_t fill;
		fill = '0;
		out_hold = 1'b1;
		@(posedge clk);
		#1;
		while (fill < fifo_level_t'(`UM_RX_THRESH))
		begin
			send_packet(port_t'($urandom_range(0, 5)), 12);
			fill += fifo_level_t'(12);
		end
		repeat (20)
		begin
			@(posedge clk);
			#1;
			check_bit(um2cdp_tx_enable, 1'b0, "um2cdp_tx_enable above threshold");
		end
		out_hold = 1'b0;
	endtask

	// output monitors sample on the falling edge
	always @(negedge clk)
	begin
		if (DUT.u_sva.assert_failures != 0)
			stop_run("bound assertions reported handshake violations");
		if (reset && um2cdp_data_valid === 1'b1)
		begin
			if (exp_flits.size() == 0)
				stop_run("flit sent to the output controller with none expected");
			else
				check_flit(um2cdp_data, exp_flits.pop_front(), "output flit");
		end
		if (reset && um2cdp_rule_wrreq === 1'b1)
		begin
			if (exp_rules.size() == 0)
				stop_run("rule written to the output controller with none expected");
			else
				check_rule(um2cdp_rule, exp_rules.pop_front(), "forwarding rule");
		end
	end

	initial
	begin
		int waited;
		void'($urandom(43));
		shadow_id = '{`UM_ID0_VAL, `UM_ID1_VAL, `UM_ID2_VAL, `UM_ID3_VAL, 0, 0, 0, 0};
		shadow_ram = '{default: '0};
		repeat (5) @(posedge clk);
		#1;
		check_bit(um2cdp_tx_enable, 1'b0, "um2cdp_tx_enable in reset");
		check_bit(um2cdp_data_valid, 1'b0, "um2cdp_data_valid in reset");
		check_bit(um2cdp_rule_wrreq, 1'b0, "um2cdp_rule_wrreq in reset");
		check_bit(localbus_ack_n, 1'b1, "localbus_ack_n in reset");
		reset = 1'b1;
		@(posedge clk);
		#1;

		for (int i = 0; i < `UM_REG_COUNT; i++)
			read_reg(`UM_BLK_ID, i);
		for (int i = 0; i < 4; i++)
		begin
			write_reg(`UM_BLK_ID, i, $urandom);	// read-only, model keeps old value
			read_reg(`UM_BLK_ID, i);
		end
		repeat (60)
		begin
			if ($urandom_range(0, 1))
				write_reg(2'($urandom_range(0, 3)), $urandom_range(0, 11), $urandom);
			else
				read_reg(2'($urandom_range(0, 3)), $urandom_range(0, 11));
		end

		fill_to_threshold();

		for (int p = 0; p < num_packets; p++)
		begin
			send_packet(port_t'($urandom_range(0, 5)), $urandom_range(2, 12));
			repeat ($urandom_range(0, 3))
			begin
				@(posedge clk);
				#1;
			end
		end

		waited = 0;
		while (exp_flits.size() != 0 || exp_rules.size() != 0)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > drain_limit)
				stop_run("timeout: expected flits or rules never came out");
		end
		repeat (10) @(posedge clk);	// catch stray outputs
		#1;
		for (int i = 0; i < `UM_REG_COUNT; i++)
		begin
			read_reg(`UM_BLK_ID, i);
			read_reg(`UM_BLK_RAM, i);
		end

		if (DUT.u_sva.assert_failures == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			stop_run("bound assertions reported handshake violations");
	end

endmodule

`default_nettype wire

/* um_passthrough.f */
+incdir+source
source/um_pkg.sv
source/pkt_rx_buffer.sv
source/pkt_forward.sv
source/rule_gen.sv
source/localbus_regs.sv
source/um_top.sv
verif/um_sva.sv
verif/um_tb.sv
